/* logic/qdrc_params.svh */
`ifndef QDRC_PARAMS_SVH
`define QDRC_PARAMS_SVH

// One beat on the QDR data pins
`define QDRC_DATA_WIDTH      36
`define QDRC_BW_WIDTH        4
`define QDRC_ADDR_WIDTH      22

// A user word is two beats
`define QDRC_WORD_WIDTH      (2 * `QDRC_DATA_WIDTH)
`define QDRC_BE_WIDTH        (2 * `QDRC_BW_WIDTH)

`define QDRC_TRAIN_PATTERN   72'h00_abcd_ef12_3456_7890
`define QDRC_CAL_RETRIES     3
`define QDRC_TIMEOUT_CYCLES  64
`define QDRC_SETTLE_CYCLES   8

// Outstanding reads the response path can track
`define QDRC_RD_FIFO_DEPTH   4

`define QDRC_PRB_WIDTH       4

`endif

/* logic/qdrc_pkg.sv */
`include "qdrc_params.svh"

package qdrc_pkg;

  typedef enum logic [1:0] {
    op_idle,
    op_read,
    op_write
  } qdr_op_e;

  typedef struct packed {
    logic                          valid;
    logic [`QDRC_ADDR_WIDTH-1:0]   addr;
    logic [`QDRC_WORD_WIDTH-1:0]   data;
    logic [`QDRC_BE_WIDTH-1:0]     be;
  } qdr_wr_req_t;

  typedef struct packed {
    logic                          valid;
    logic [`QDRC_ADDR_WIDTH-1:0]   addr;
    logic                          train;  // Response belongs to calibration
  } qdr_rd_req_t;

  typedef struct packed {
    qdr_op_e                       op;
    logic [`QDRC_ADDR_WIDTH-1:0]   addr;
  } qdr_slot_t;

  typedef struct packed {
    logic                          valid;
    logic [`QDRC_WORD_WIDTH-1:0]   data;
    logic                          train;
  } qdr_rd_rsp_t;

  typedef enum logic [`QDRC_PRB_WIDTH-1:0] {
    phy_reset,
    phy_wait_idelay,
    phy_train,
    phy_ready,
    phy_fail
  } phy_state_e;

  typedef enum logic [`QDRC_PRB_WIDTH-1:0] {
    tr_write_pattern,
    tr_read_pattern,
    tr_wait_data,
    tr_compare
  } train_state_e;

  typedef enum logic [`QDRC_PRB_WIDTH-1:0] {
    al_wait_qvld,
    al_beat0,
    al_beat1
  } align_state_e;

endpackage

/* logic/qdrc_phy_init.sv */
`timescale 1ns/1ps
`include "qdrc_params.svh"

module qdrc_phy_init (
  input  logic                          clk0,
  input  logic                          qdr_rst,
  input  logic                          usr_rd_strb,
  input  logic                          usr_wr_strb,
  input  logic [`QDRC_ADDR_WIDTH-1:0]   usr_addr,
  input  logic [`QDRC_WORD_WIDTH-1:0]   usr_wr_data,
  input  logic [`QDRC_BE_WIDTH-1:0]     usr_wr_be,
  input  qdrc_pkg::qdr_rd_rsp_t         rd_rsp,
  output qdrc_pkg::qdr_wr_req_t         wr_req,
  output qdrc_pkg::qdr_rd_req_t         rd_req,
  output logic                          phy_rdy,
  output logic                          cal_fail,
  output logic [`QDRC_PRB_WIDTH-1:0]    bit_train_state_prb,
  output logic [`QDRC_PRB_WIDTH-1:0]    bit_train_error_prb,
  output logic [`QDRC_PRB_WIDTH-1:0]    phy_state_prb
);

  localparam int CNT_W       = $clog2(`QDRC_TIMEOUT_CYCLES) + 1;
  localparam int PRB_W       = `QDRC_PRB_WIDTH;
  localparam int RD_ISSUE_AT = 4;  // Gives the pattern write time to reach the array

  qdrc_pkg::phy_state_e         phy_state;
  qdrc_pkg::train_state_e       train_state;
  logic [CNT_W-1:0]             attempt_cnt;
  logic [PRB_W-1:0]             err_cnt;
  logic [`QDRC_WORD_WIDTH-1:0]  train_word;
  logic                         train_hit;
  logic                         attempt_timeout;
  logic                         pattern_ok;
  logic                         train_rsp;

  assign train_rsp       = rd_rsp.valid && rd_rsp.train;
  assign attempt_timeout = attempt_cnt == CNT_W'(`QDRC_TIMEOUT_CYCLES - 2);
  assign pattern_ok      = train_hit && (train_word == `QDRC_TRAIN_PATTERN);

  always_ff @(posedge clk0) begin
    if (qdr_rst) begin
      phy_state   <= qdrc_pkg::phy_reset;
      train_state <= qdrc_pkg::tr_write_pattern;
      attempt_cnt <= '0;
      err_cnt     <= '0;
      train_hit   <= 1'b0;
    end else begin
      case (phy_state)
        qdrc_pkg::phy_reset: begin
          phy_state   <= qdrc_pkg::phy_wait_idelay;
          attempt_cnt <= '0;
        end
        qdrc_pkg::phy_wait_idelay: begin
          attempt_cnt <= attempt_cnt + 1'b1;
          if (attempt_cnt == CNT_W'(`QDRC_SETTLE_CYCLES - 1)) begin
            phy_state   <= qdrc_pkg::phy_train;
            train_state <= qdrc_pkg::tr_write_pattern;
            attempt_cnt <= '0;
          end
        end
        qdrc_pkg::phy_train: begin
          attempt_cnt <= attempt_cnt + 1'b1;
          case (train_state)
            qdrc_pkg::tr_write_pattern: begin
              train_state <= qdrc_pkg::tr_read_pattern;
            end
            qdrc_pkg::tr_read_pattern: begin
              if (attempt_cnt == CNT_W'(RD_ISSUE_AT)) begin
                train_state <= qdrc_pkg::tr_wait_data;
              end
            end
            qdrc_pkg::tr_wait_data: begin
              if (train_rsp) begin
                train_hit   <= 1'b1;
                train_state <= qdrc_pkg::tr_compare;
              end else if (attempt_timeout) begin
                train_hit   <= 1'b0;  // Nothing came back in time
                train_state <= qdrc_pkg::tr_compare;
              end
            end
            default: begin
              attempt_cnt <= '0;
              train_state <= qdrc_pkg::tr_write_pattern;
              if (pattern_ok) begin
                phy_state <= qdrc_pkg::phy_ready;
              end else begin
                err_cnt <= err_cnt + 1'b1;
                if (err_cnt == PRB_W'(`QDRC_CAL_RETRIES - 1)) begin
                  phy_state <= qdrc_pkg::phy_fail;
                end
              end
            end
          endcase
        end
        default: begin
          attempt_cnt <= attempt_cnt;  // Ready and fail are terminal until reset
        end
      endcase
    end
  end

  always_ff @(posedge clk0) begin
    if (train_rsp) begin
      train_word <= rd_rsp.data;
    end
  end

  // During calibration the request registers carry the training traffic
  always_ff @(posedge clk0) begin
    if (qdr_rst) begin
      wr_req.valid <= 1'b0;
      rd_req.valid <= 1'b0;
    end else if (phy_state == qdrc_pkg::phy_ready) begin
      wr_req.valid <= usr_wr_strb;
      wr_req.addr  <= usr_addr;
      wr_req.data  <= usr_wr_data;
      wr_req.be    <= usr_wr_be;
      rd_req.valid <= usr_rd_strb;
      rd_req.addr  <= usr_addr;
      rd_req.train <= 1'b0;
    end else begin
      wr_req.valid <= (phy_state == qdrc_pkg::phy_train) &&
                      (train_state == qdrc_pkg::tr_write_pattern);
      wr_req.addr  <= '0;
      wr_req.data  <= `QDRC_TRAIN_PATTERN;
      wr_req.be    <= '1;
      rd_req.valid <= (phy_state == qdrc_pkg::phy_train) &&
                      (train_state == qdrc_pkg::tr_read_pattern) &&
                      (attempt_cnt == CNT_W'(RD_ISSUE_AT));
      rd_req.addr  <= '0;
      rd_req.train <= 1'b1;
    end
  end

  assign phy_rdy             = phy_state == qdrc_pkg::phy_ready;
  assign cal_fail            = phy_state == qdrc_pkg::phy_fail;
  assign phy_state_prb       = phy_state;
  assign bit_train_state_prb = train_state;
  assign bit_train_error_prb = err_cnt;

  a_rdy_fail_excl: assert property (@(posedge clk0) disable iff (qdr_rst)
    !(phy_rdy && cal_fail))
    else $error("phy_rdy and cal_fail both high");

  // Every attempt is bounded, so calibration ends within the retry budget
  a_cal_bounded: assert property (@(posedge clk0) disable iff (qdr_rst)
    $rose(phy_state == qdrc_pkg::phy_train) |->
      ##[1:`QDRC_CAL_RETRIES * `QDRC_TIMEOUT_CYCLES] (phy_rdy || cal_fail))
    else $error("calibration did not finish within its timeout");

endmodule

/* logic/qdrc_wr_path.sv */
`timescale 1ns/1ps
`include "qdrc_params.svh"

module qdrc_wr_path (
  input  logic                          clk0,
  input  logic                          qdr_rst,
  input  qdrc_pkg::qdr_wr_req_t         wr_req,
  input  logic                          wr_grant,
  output qdrc_pkg::qdr_slot_t           wr_slot,
  output logic [`QDRC_DATA_WIDTH-1:0]   qdr_d,
  output logic [`QDRC_BW_WIDTH-1:0]     qdr_bw_n
);

  localparam int DW = `QDRC_DATA_WIDTH;
  localparam int BW = `QDRC_BW_WIDTH;

  qdrc_pkg::qdr_wr_req_t  held;  // Request still waiting for its grant
  qdrc_pkg::qdr_wr_req_t  src;
  logic                   beat1_pend;
  logic [DW-1:0]          beat1_d;
  logic [BW-1:0]          beat1_be;

  assign src = held.valid ? held : wr_req;

  // The arbiter keeps the address of a delayed write, so the slot is a single pulse
  assign wr_slot.op   = wr_req.valid ? qdrc_pkg::op_write : qdrc_pkg::op_idle;
  assign wr_slot.addr = wr_req.addr;

  always_ff @(posedge clk0) begin
    if (qdr_rst) begin
      held.valid <= 1'b0;
      beat1_pend <= 1'b0;
      qdr_bw_n   <= '1;
    end else begin
      if (wr_grant) begin
        held.valid <= 1'b0;
      end else if (wr_req.valid) begin
        held <= wr_req;
      end
      beat1_pend <= wr_grant;
      if (wr_grant) begin
        qdr_bw_n <= ~src.be[BW-1:0];  // Lanes are active low on the pins
      end else if (beat1_pend) begin
        qdr_bw_n <= ~beat1_be;
      end else begin
        qdr_bw_n <= '1;
      end
    end
  end

  always_ff @(posedge clk0) begin
    if (wr_grant) begin
      qdr_d    <= src.data[DW-1:0];
      beat1_d  <= src.data[2*DW-1:DW];
      beat1_be <= src.be[2*BW-1:BW];
    end else if (beat1_pend) begin
      qdr_d <= beat1_d;
    end
  end

  a_no_req_in_flight: assert property (@(posedge clk0) disable iff (qdr_rst)
    wr_req.valid |-> !held.valid)
    else $error("write request arrived while another was waiting for grant");

  // The arbiter must leave room for the second beat
  a_grant_spacing: assert property (@(posedge clk0) disable iff (qdr_rst)
    wr_grant |-> !beat1_pend)
    else $error("write granted while beat 1 of the previous burst is pending");

endmodule

/* logic/qdrc_rd_path.sv */
`timescale 1ns/1ps
`include "qdrc_params.svh"

module qdrc_rd_path (
  input  logic                          clk0,
  input  logic                          qdr_rst,
  input  qdrc_pkg::qdr_rd_req_t         rd_req,
  input  logic [`QDRC_DATA_WIDTH-1:0]   qdr_q,
  input  logic                          qdr_qvld,
  output qdrc_pkg::qdr_slot_t           rd_slot,
  output qdrc_pkg::qdr_rd_rsp_t         rd_rsp,
  output logic [`QDRC_WORD_WIDTH-1:0]   usr_rd_data,
  output logic                          usr_rd_dvld,
  output logic [`QDRC_PRB_WIDTH-1:0]    bit_align_state_prb
);

  localparam int DEPTH = `QDRC_RD_FIFO_DEPTH;
  localparam int PTR_W = $clog2(DEPTH);

  logic                          tag_mem [DEPTH];
  logic [PTR_W-1:0]              wr_ptr;
  logic [PTR_W-1:0]              rd_ptr;
  logic [PTR_W:0]                count;
  logic                          push;
  logic                          pop;
  logic                          tag_head;
  logic [`QDRC_DATA_WIDTH-1:0]   beat0_q;
  qdrc_pkg::align_state_e        align_state;

  // Reads always win arbitration, so the slot needs no holding
  assign rd_slot.op   = rd_req.valid ? qdrc_pkg::op_read : qdrc_pkg::op_idle;
  assign rd_slot.addr = rd_req.addr;

  assign push     = rd_req.valid;
  assign pop      = (align_state == qdrc_pkg::al_beat1) && qdr_qvld;
  assign tag_head = tag_mem[rd_ptr];

  assign bit_align_state_prb = align_state;

  always_ff @(posedge clk0) begin
    if (push) begin
      tag_mem[wr_ptr] <= rd_req.train;
    end
  end

  always_ff @(posedge clk0) begin
    if (qdr_rst) begin
      wr_ptr       <= '0;
      rd_ptr       <= '0;
      count        <= '0;
      align_state  <= qdrc_pkg::al_wait_qvld;
      usr_rd_dvld  <= 1'b0;
      rd_rsp.valid <= 1'b0;
    end else begin
      wr_ptr <= wr_ptr + PTR_W'(push);
      rd_ptr <= rd_ptr + PTR_W'(pop);
      count  <= count + (PTR_W + 1)'(push) - (PTR_W + 1)'(pop);
      case (align_state)
        qdrc_pkg::al_wait_qvld: begin
          if (qdr_qvld) begin
            align_state <= qdrc_pkg::al_beat1;
          end else if (count != '0) begin
            align_state <= qdrc_pkg::al_beat0;
          end
        end
        qdrc_pkg::al_beat0: begin
          if (qdr_qvld) begin
            align_state <= qdrc_pkg::al_beat1;
          end
        end
        default: begin
          if (qdr_qvld) begin
            align_state <= qdrc_pkg::al_wait_qvld;
          end
        end
      endcase
      usr_rd_dvld  <= pop && !tag_head;
      rd_rsp.valid <= pop && tag_head;
      rd_rsp.train <= tag_head;
      rd_rsp.data  <= {qdr_q, beat0_q};
    end
  end

  always_ff @(posedge clk0) begin
    if (qdr_qvld && align_state != qdrc_pkg::al_beat1) begin
      beat0_q <= qdr_q;  // Low half of the word
    end
    if (pop) begin
      usr_rd_data <= {qdr_q, beat0_q};
    end
  end

  a_qvld_expected: assert property (@(posedge clk0) disable iff (qdr_rst)
    qdr_qvld |-> count != '0)
    else $error("qdr_qvld with no read outstanding");

  a_fifo_room: assert property (@(posedge clk0) disable iff (qdr_rst)
    push |-> (count < (PTR_W + 1)'(DEPTH)) || pop)
    else $error("read tag FIFO overflow");

endmodule

/* logic/qdrc_addr_arb.sv */
`timescale 1ns/1ps
`include "qdrc_params.svh"

module qdrc_addr_arb (
  input  logic                          clk0,
  input  logic                          qdr_rst,
  input  qdrc_pkg::qdr_slot_t           rd_slot,
  input  qdrc_pkg::qdr_slot_t           wr_slot,
  output logic                          wr_grant,
  output logic [`QDRC_ADDR_WIDTH-1:0]   qdr_sa,
  output logic                          qdr_r_n,
  output logic                          qdr_w_n
);

  logic                          pend_valid;
  logic [`QDRC_ADDR_WIDTH-1:0]   pend_addr;
  logic                          rd_go;
  logic                          wr_want;
  logic                          wr_go;
  logic [`QDRC_ADDR_WIDTH-1:0]   wr_addr;

  assign rd_go   = rd_slot.op == qdrc_pkg::op_read;
  assign wr_want = pend_valid || (wr_slot.op == qdrc_pkg::op_write);
  assign wr_addr = pend_valid ? pend_addr : wr_slot.addr;

  // A write on the pins this cycle still owns qdr_d for its second beat
  assign wr_go    = wr_want && !rd_go && qdr_w_n;
  assign wr_grant = wr_go;

  always_ff @(posedge clk0) begin
    if (qdr_rst) begin
      qdr_r_n    <= 1'b1;
      qdr_w_n    <= 1'b1;
      pend_valid <= 1'b0;
    end else begin
      qdr_r_n    <= !rd_go;
      qdr_w_n    <= !wr_go;
      pend_valid <= wr_want && !wr_go;
    end
  end

  always_ff @(posedge clk0) begin
    if (wr_want && !wr_go) begin
      pend_addr <= wr_addr;
    end
    if (rd_go) begin
      qdr_sa <= rd_slot.addr;
    end else if (wr_go) begin
      qdr_sa <= wr_addr;
    end
  end

  a_one_cmd: assert property (@(posedge clk0) disable iff (qdr_rst)
    !(!qdr_r_n && !qdr_w_n))
    else $error("qdr_r_n and qdr_w_n low together");

  // Only one write can wait, so a second one must not arrive behind it
  a_pend_free: assert property (@(posedge clk0) disable iff (qdr_rst)
    pend_valid |-> wr_slot.op != qdrc_pkg::op_write)
    else $error("new write while a write is pending");

endmodule

/* logic/qdr_controller.sv */
`timescale 1ns/1ps
`include "qdrc_params.svh"

module qdr_controller (
  input  logic                          clk0,
  input  logic                          reset,      // Held until clocks and delays are stable
  input  logic                          idelay_rdy,

  output logic [`QDRC_DATA_WIDTH-1:0]   qdr_d,
  input  logic [`QDRC_DATA_WIDTH-1:0]   qdr_q,
  output logic [`QDRC_ADDR_WIDTH-1:0]   qdr_sa,
  output logic                          qdr_w_n,
  output logic                          qdr_r_n,
  output logic [`QDRC_BW_WIDTH-1:0]     qdr_bw_n,
  input  logic                          qdr_qvld,

  output logic                          phy_rdy,
  output logic                          cal_fail,

  output logic [`QDRC_PRB_WIDTH-1:0]    bit_align_state_prb,
  output logic [`QDRC_PRB_WIDTH-1:0]    bit_train_state_prb,
  output logic [`QDRC_PRB_WIDTH-1:0]    bit_train_error_prb,
  output logic [`QDRC_PRB_WIDTH-1:0]    phy_state_prb,

  input  logic                          usr_rd_strb,
  input  logic                          usr_wr_strb,
  input  logic [`QDRC_ADDR_WIDTH-1:0]   usr_addr,
  output logic [`QDRC_WORD_WIDTH-1:0]   usr_rd_data,
  output logic                          usr_rd_dvld,
  input  logic [`QDRC_WORD_WIDTH-1:0]   usr_wr_data,
  input  logic [`QDRC_BE_WIDTH-1:0]     usr_wr_be
);

  logic                   qdr_rst;
  logic                   wr_grant;
  qdrc_pkg::qdr_wr_req_t  wr_req;
  qdrc_pkg::qdr_rd_req_t  rd_req;
  qdrc_pkg::qdr_rd_rsp_t  rd_rsp;
  qdrc_pkg::qdr_slot_t    wr_slot;
  qdrc_pkg::qdr_slot_t    rd_slot;

  assign qdr_rst = reset || !idelay_rdy;

  qdrc_phy_init qdrc_phy_init_inst (
    .clk0                (clk0),
    .qdr_rst             (qdr_rst),
    .usr_rd_strb         (usr_rd_strb),
    .usr_wr_strb         (usr_wr_strb),
    .usr_addr            (usr_addr),
    .usr_wr_data         (usr_wr_data),
    .usr_wr_be           (usr_wr_be),
    .rd_rsp              (rd_rsp),
    .wr_req              (wr_req),
    .rd_req              (rd_req),
    .phy_rdy             (phy_rdy),
    .cal_fail            (cal_fail),
    .bit_train_state_prb (bit_train_state_prb),
    .bit_train_error_prb (bit_train_error_prb),
    .phy_state_prb       (phy_state_prb)
  );

  qdrc_wr_path qdrc_wr_path_inst (
    .clk0     (clk0),
    .qdr_rst  (qdr_rst),
    .wr_req   (wr_req),
    .wr_grant (wr_grant),
    .wr_slot  (wr_slot),
    .qdr_d    (qdr_d),
    .qdr_bw_n (qdr_bw_n)
  );

  qdrc_rd_path qdrc_rd_path_inst (
    .clk0                (clk0),
    .qdr_rst             (qdr_rst),
    .rd_req              (rd_req),
    .qdr_q               (qdr_q),
    .qdr_qvld            (qdr_qvld),
    .rd_slot             (rd_slot),
    .rd_rsp              (rd_rsp),
    .usr_rd_data         (usr_rd_data),
    .usr_rd_dvld         (usr_rd_dvld),
    .bit_align_state_prb (bit_align_state_prb)
  );

  qdrc_addr_arb qdrc_addr_arb_inst (
    .clk0     (clk0),
    .qdr_rst  (qdr_rst),
    .rd_slot  (rd_slot),
    .wr_slot  (wr_slot),
    .wr_grant (wr_grant),
    .qdr_sa   (qdr_sa),
    .qdr_r_n  (qdr_r_n),
    .qdr_w_n  (qdr_w_n)
  );

endmodule

/* testbench/qdr_sram_model.sv */
`timescale 1ns/1ps
`include "qdrc_params.svh"

module qdr_sram_model (
  input  logic                          clk0,
  input  logic [`QDRC_DATA_WIDTH-1:0]   qdr_d,
  output logic [`QDRC_DATA_WIDTH-1:0]   qdr_q,
  input  logic [`QDRC_ADDR_WIDTH-1:0]   qdr_sa,
  input  logic                          qdr_w_n,
  input  logic                          qdr_r_n,
  input  logic [`QDRC_BW_WIDTH-1:0]     qdr_bw_n,
  output logic                          qdr_qvld,
  input  logic                          fault_en,
  input  logic [5:0]                    fault_bit,
  input  logic                          fault_val
);

  localparam int DW   = `QDRC_DATA_WIDTH;
  localparam int AW   = `QDRC_ADDR_WIDTH;
  localparam int BW   = `QDRC_BW_WIDTH;
  localparam int LANE = DW / BW;

  logic [2*DW-1:0]  mem [logic [AW-1:0]];  // Sparse array, one entry per burst address
  logic [AW-1:0]    wr_addr;
  logic             wr_beat1;
  logic             rd_s1_vld;
  logic             rd_s2_vld;
  logic [2*DW-1:0]  rd_s1_word;
  logic [2*DW-1:0]  rd_s2_word;
  logic [DW-1:0]    q_raw;
  logic [DW-1:0]    q_beat1;
  logic             q_beat1_pend;
  logic [DW-1:0]    fault_mask;

  // Never written locations return a word built from the whole address
  function automatic logic [2*DW-1:0] read_word(input logic [AW-1:0] addr);
    if (mem.exists(addr)) begin
      return mem[addr];
    end
    return {{(2*DW - 3*AW){1'b1}}, addr, ~addr, addr};
  endfunction

  function automatic logic [DW-1:0] merge_lanes(input logic [DW-1:0] old_half,
                                                input logic [DW-1:0] new_half,
                                                input logic [BW-1:0] bw_n);
    logic [DW-1:0] res;
    res = old_half;
    for (int i = 0; i < BW; i++) begin
      if (!bw_n[i]) begin
        res[i*LANE +: LANE] = new_half[i*LANE +: LANE];
      end
    end
    return res;
  endfunction

  always @(posedge clk0) begin
    logic [2*DW-1:0] cur;
    // Reads look at the array before this edge's writes land
    rd_s1_vld  <= (qdr_r_n === 1'b0);
    rd_s1_word <= read_word(qdr_sa);
    rd_s2_vld  <= rd_s1_vld;
    rd_s2_word <= rd_s1_word;
    if (q_beat1_pend === 1'b1) begin
      q_raw        <= q_beat1;
      qdr_qvld     <= 1'b1;
      q_beat1_pend <= 1'b0;
    end else if (rd_s2_vld === 1'b1) begin
      q_raw        <= rd_s2_word[DW-1:0];
      q_beat1      <= rd_s2_word[2*DW-1:DW];
      qdr_qvld     <= 1'b1;
      q_beat1_pend <= 1'b1;
    end else begin
      qdr_qvld     <= 1'b0;
      q_beat1_pend <= 1'b0;
    end
    if (qdr_w_n === 1'b0) begin
      cur = read_word(qdr_sa);
      cur[DW-1:0] = merge_lanes(cur[DW-1:0], qdr_d, qdr_bw_n);  // Beat 0 is the low half
      mem[qdr_sa] = cur;
    end
    if (wr_beat1 === 1'b1) begin
      cur = read_word(wr_addr);
      cur[2*DW-1:DW] = merge_lanes(cur[2*DW-1:DW], qdr_d, qdr_bw_n);
      mem[wr_addr] = cur;
    end
    wr_beat1 <= (qdr_w_n === 1'b0);
    wr_addr  <= qdr_sa;
  end

  assign fault_mask = DW'(1) << fault_bit;
  assign qdr_q = fault_en ? ((q_raw & ~fault_mask) | (fault_val ? fault_mask : '0)) : q_raw;

endmodule

/* testbench/tb_qdr_controller.sv */
`timescale 1ns/1ps
`include "qdrc_params.svh"

module tb_qdr_controller;

  localparam int AW    = `QDRC_ADDR_WIDTH;
  localparam int DW    = `QDRC_DATA_WIDTH;
  localparam int WW    = `QDRC_WORD_WIDTH;
  localparam int BEW   = `QDRC_BE_WIDTH;
  localparam int PW    = `QDRC_PRB_WIDTH;
  localparam int LANE  = WW / BEW;
  localparam int N_WR  = 64;
  localparam int N_BE  = 32;
  localparam int N_MIX = 16;
  localparam int N_DEAD_STRB = 4;
  localparam int NUM_OPS  = 2 * N_WR + 2 * N_BE + 3 * N_MIX + 2 * N_DEAD_STRB;
  localparam int WD_CYCLES = (`QDRC_CAL_RETRIES + 2) * `QDRC_TIMEOUT_CYCLES + 20 * NUM_OPS;
  localparam int CAL_WAIT =
    `QDRC_SETTLE_CYCLES + `QDRC_CAL_RETRIES * `QDRC_TIMEOUT_CYCLES + 16;

  logic            clk0;
  logic            reset;
  logic            idelay_rdy;
  logic [DW-1:0]   qdr_d;
  logic [DW-1:0]   qdr_q;
  logic [AW-1:0]   qdr_sa;
  logic            qdr_w_n;
  logic            qdr_r_n;
  logic [3:0]      qdr_bw_n;
  logic            qdr_qvld;
  logic            phy_rdy;
  logic            cal_fail;
  logic [PW-1:0]   bit_align_state_prb;
  logic [PW-1:0]   bit_train_state_prb;
  logic [PW-1:0]   bit_train_error_prb;
  logic [PW-1:0]   phy_state_prb;
  logic            usr_rd_strb;
  logic            usr_wr_strb;
  logic [AW-1:0]   usr_addr;
  logic [WW-1:0]   usr_rd_data;
  logic            usr_rd_dvld;
  logic [WW-1:0]   usr_wr_data;
  logic [BEW-1:0]  usr_wr_be;
  logic            fault_en;
  logic [5:0]      fault_bit;
  logic            fault_val;

  logic [WW-1:0]   ref_mem [logic [AW-1:0]];
  logic [WW-1:0]   exp_q [$];  // Expected user read data in issue order
  logic [AW-1:0]   wr_addrs [N_WR];
  int              checks;
  int              errors;
  int              tests;
  int              failed_tests;
  int              test_err_start;
  string           cur_test;

  qdr_controller qdr_controller_inst (.*);

  qdr_sram_model qdr_sram_model_inst (.*);

  always #20 clk0 = ~clk0;

  task automatic check_value(input logic [WW-1:0] actual, input logic [WW-1:0] expected,
                             input string what);
    checks++;
    if (actual !== expected) begin
      errors++;
      $display("FAILED at %0t ns: %s, got %h, expected %h", $time, what, actual, expected);
    end
  endtask

  task automatic report_error(input string what);
    errors++;
    $display("Error at %0t ns: %s", $time, what);
  endtask

  task automatic start_test(input string name);
    cur_test = name;
    test_err_start = errors;
  endtask

  task automatic end_test();
    tests++;
    if (errors != test_err_start) begin
      failed_tests++;
    end
    $display("%s finished: %s, %0d errors", cur_test,
             (errors == test_err_start) ? "ok" : "failed", errors - test_err_start);
  endtask

  function automatic logic [AW-1:0] rand_addr();
    logic [31:0] r;
    r = $urandom;
    return r[AW-1:0];
  endfunction

  function automatic logic [WW-1:0] rand_word();
    logic [95:0] r;
    r = {$urandom, $urandom, $urandom};
    return r[WW-1:0];
  endfunction

  function automatic logic [BEW-1:0] rand_be();
    logic [31:0] r;
    r = $urandom;
    return r[BEW-1:0];
  endfunction

  // Each enable bit owns one 9-bit lane of the word
  function automatic void ref_write(input logic [AW-1:0] addr, input logic [WW-1:0] data,
                                    input logic [BEW-1:0] be);
    logic [WW-1:0] word;
    word = ref_mem.exists(addr) ? ref_mem[addr] : '0;
    for (int j = 0; j < BEW; j++) begin
      if (be[j]) begin
        word[j*LANE +: LANE] = data[j*LANE +: LANE];
      end
    end
    ref_mem[addr] = word;
  endfunction

  task automatic apply_reset();
    @(posedge clk0);
    reset      <= 1'b1;
    idelay_rdy <= 1'b0;
    repeat (8) @(posedge clk0);
    idelay_rdy <= 1'b1;
    repeat (8) @(posedge clk0);
    reset      <= 1'b0;
  endtask

  task automatic wait_cal_end(output bit done);
    done = 1'b0;
    for (int i = 0; i < CAL_WAIT && !done; i++) begin
      @(negedge clk0);
      done = phy_rdy || cal_fail;
    end
  endtask

  task automatic send_write(input logic [AW-1:0] addr, input logic [WW-1:0] data,
                            input logic [BEW-1:0] be);
    @(posedge clk0);
    usr_wr_strb <= 1'b1;
    usr_addr    <= addr;
    usr_wr_data <= data;
    usr_wr_be   <= be;
    ref_write(addr, data, be);
    @(posedge clk0);
    usr_wr_strb <= 1'b0;
  endtask

  task automatic send_read(input logic [AW-1:0] addr);
    @(posedge clk0);
    usr_rd_strb <= 1'b1;
    usr_addr    <= addr;
    exp_q.push_back(ref_mem[addr]);
    @(posedge clk0);
    usr_rd_strb <= 1'b0;
  endtask

  // Read and write share usr_addr, and the read sees the word from before the write
  task automatic send_read_write(input logic [AW-1:0] addr, input logic [WW-1:0] data,
                                 input logic [BEW-1:0] be);
    @(posedge clk0);
    usr_rd_strb <= 1'b1;
    usr_wr_strb <= 1'b1;
    usr_addr    <= addr;
    usr_wr_data <= data;
    usr_wr_be   <= be;
    exp_q.push_back(ref_mem[addr]);
    ref_write(addr, data, be);
    @(posedge clk0);
    usr_rd_strb <= 1'b0;
    usr_wr_strb <= 1'b0;
  endtask

  task automatic strobe_while_failed(input logic [AW-1:0] addr);
    @(posedge clk0);
    usr_rd_strb <= 1'b1;
    usr_wr_strb <= 1'b1;
    usr_addr    <= addr;
    @(posedge clk0);
    usr_rd_strb <= 1'b0;
    usr_wr_strb <= 1'b0;
    repeat (4) begin
      @(negedge clk0);
      check_value({qdr_w_n, qdr_r_n}, 2'b11, "command pins active after cal_fail");
    end
  endtask

  task automatic drain_reads();
    for (int i = 0; i < 100 && exp_q.size() != 0; i++) begin
      @(negedge clk0);
    end
    if (exp_q.size() != 0) begin
      report_error($sformatf("%0d reads never returned data", exp_q.size()));
      exp_q.delete();
    end
    repeat (8) @(negedge clk0);  // Room for a stray extra response to show up
    check_value(bit_align_state_prb, qdrc_pkg::al_wait_qvld, "bit_align_state_prb when idle");
  endtask

  always @(negedge clk0) begin
    if (usr_rd_dvld === 1'b1) begin
      if (exp_q.size() == 0) begin
        report_error("usr_rd_dvld pulsed with no read outstanding");
      end else begin
        check_value(usr_rd_data, exp_q.pop_front(), "user read data");
      end
    end
  end

  initial begin
    #(WD_CYCLES * 40);
    $display("Watchdog expired: test %s did not finish in time", cur_test);
    $display("TEST FAIL");
    $finish;
  end

  initial begin
    bit             done;
    int             idx;
    logic [AW-1:0]  a;
    void'($urandom(32'h4658267f));
    clk0        = 1'b0;
    reset       = 1'b1;
    idelay_rdy  = 1'b0;
    usr_rd_strb = 1'b0;
    usr_wr_strb = 1'b0;
    usr_addr    = '0;
    usr_wr_data = '0;
    usr_wr_be   = '0;
    fault_en    = 1'b0;
    fault_bit   = 6'd0;
    fault_val   = 1'b1;  // Bit 0 of the training word is zero
    checks = 0;
    errors = 0;
    tests = 0;
    failed_tests = 0;
    cur_test = "reset";
    apply_reset();

    start_test("calibration");
    wait_cal_end(done);
    if (!done) begin
      report_error("calibration neither passed nor failed in time");
    end
    check_value(phy_rdy, 1'b1, "phy_rdy after calibration");
    check_value(cal_fail, 1'b0, "cal_fail after calibration");
    check_value(phy_state_prb, qdrc_pkg::phy_ready, "phy_state_prb after calibration");
    check_value(bit_train_state_prb, qdrc_pkg::tr_write_pattern,
                "bit_train_state_prb after calibration");
    end_test();

    start_test("write_read");
    for (int i = 0; i < N_WR; i++) begin
      wr_addrs[i] = rand_addr();
      send_write(wr_addrs[i], rand_word(), '1);
    end
    for (int i = 0; i < N_WR; i++) begin
      send_read(wr_addrs[i]);
    end
    drain_reads();
    end_test();

    start_test("byte_enables");
    for (int i = 0; i < N_BE; i++) begin
      idx = $urandom % N_WR;
      send_write(wr_addrs[idx], rand_word(), rand_be());
      send_read(wr_addrs[idx]);
    end
    drain_reads();
    end_test();

    start_test("read_write_same_cycle");
    for (int i = 0; i < N_MIX; i++) begin
      a = wr_addrs[$urandom % N_WR];
      send_read_write(a, rand_word(), rand_be());
      repeat (3) @(posedge clk0);
      send_read(a);
      repeat (3) @(posedge clk0);
    end
    drain_reads();
    end_test();

    start_test("calibration_fault");
    @(posedge clk0);
    fault_en <= 1'b1;
    apply_reset();
    wait_cal_end(done);
    if (!done) begin
      report_error("faulty calibration never reached cal_fail");
    end
    check_value(cal_fail, 1'b1, "cal_fail with stuck bit");
    check_value(phy_rdy, 1'b0, "phy_rdy with stuck bit");
    check_value(bit_train_error_prb, `QDRC_CAL_RETRIES, "bit_train_error_prb");
    for (int i = 0; i < N_DEAD_STRB; i++) begin
      strobe_while_failed(rand_addr());
    end
    end_test();

    $display("tests %0d, tests failed %0d, checks %0d, errors %0d",
             tests, failed_tests, checks, errors);
    if (errors == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

endmodule

/* sim.f */
+incdir+logic
logic/qdrc_pkg.sv
logic/qdrc_phy_init.sv
logic/qdrc_wr_path.sv
logic/qdrc_rd_path.sv
logic/qdrc_addr_arb.sv
logic/qdr_controller.sv
testbench/qdr_sram_model.sv
testbench/tb_qdr_controller.sv
